/* filelist.f */
+incdir+include
+incdir+dv
design/bpu_pkg.sv
design/return_address_stack.sv
design/branch_target_buffer.sv
design/branch_history_table.sv
design/next_pc_gen.sv
design/branch_prediction_unit.sv
dv/bpu_tb.sv

/* Makefile */
# Verilator build and run for the branch prediction unit testbench

VERILATOR  ?= verilator
TOP        ?= bpu_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
PASS_MSG   ?= sim passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell sed -n 's/^\([^+].*\)$$/\1/p' $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	./$(SIM_BIN) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

/* dv/bpu_vectors.svh */
// Branch prediction unit vector table
// One row per cycle with pending update and redirect fields, credit and expectation

`ifndef BPU_VECTORS_SVH
`define BPU_VECTORS_SVH

// add_row takes credit, gap, valid, pc, target, type, taken and ras pointer
// with_upd takes type, pc, target and taken
// with_redir takes kind, pc, ras pointer and ras target
task automatic fill_vectors();
    // Sequential fetch stops when credits run out and resumes per returned credit
    add_row(0, 0, 1, 30'h400, 30'h401, bpu_pkg::BR_NONE, 0, 0);
    add_row(0, 0, 1, 30'h401, 30'h402, bpu_pkg::BR_NONE, 0, 0);
    add_row(0, 0, 1, 30'h402, 30'h403, bpu_pkg::BR_NONE, 0, 0);
    add_row(0, 0, 1, 30'h403, 30'h404, bpu_pkg::BR_NONE, 0, 0);
    add_row(0, 0, 0, 30'h404, 30'h000, bpu_pkg::BR_NONE, 0, 0);
    add_row(1, 1, 0, 30'h404, 30'h000, bpu_pkg::BR_NONE, 0, 0);
    add_row(0, 0, 1, 30'h404, 30'h405, bpu_pkg::BR_NONE, 0, 0);
    add_row(1, 1, 0, 30'h405, 30'h000, bpu_pkg::BR_NONE, 0, 0);
    add_row(1, 0, 1, 30'h405, 30'h406, bpu_pkg::BR_NONE, 0, 0);

    // ========================================================================
    // Conditional branch at 0x410 walking its counter through 00 01 10 01 00
    // ========================================================================
    with_upd(bpu_pkg::BR_COND, 30'h410, 30'h485, 0);
    with_redir(bpu_pkg::REDIR_RESTORE, 30'h410, 0, 30'h000);
    add_row(0, 0, 0, 30'h406, 30'h000, bpu_pkg::BR_NONE, 0, 0);
    add_row(1, 0, 1, 30'h410, 30'h411, bpu_pkg::BR_COND, 0, 0);
    with_upd(bpu_pkg::BR_COND, 30'h410, 30'h485, 1);
    with_redir(bpu_pkg::REDIR_RESTORE, 30'h410, 0, 30'h000);
    add_row(0, 0, 0, 30'h411, 30'h000, bpu_pkg::BR_NONE, 0, 0);
    add_row(1, 0, 1, 30'h410, 30'h411, bpu_pkg::BR_COND, 0, 0);
    with_upd(bpu_pkg::BR_COND, 30'h410, 30'h485, 1);
    with_redir(bpu_pkg::REDIR_RESTORE, 30'h410, 0, 30'h000);
    add_row(0, 0, 0, 30'h411, 30'h000, bpu_pkg::BR_NONE, 0, 0);
    add_row(1, 0, 1, 30'h410, 30'h485, bpu_pkg::BR_COND, 1, 0);
    with_upd(bpu_pkg::BR_COND, 30'h410, 30'h485, 0);
    with_redir(bpu_pkg::REDIR_RESTORE, 30'h410, 0, 30'h000);
    add_row(0, 0, 0, 30'h485, 30'h000, bpu_pkg::BR_NONE, 0, 0);
    add_row(1, 0, 1, 30'h410, 30'h411, bpu_pkg::BR_COND, 0, 0);
    with_upd(bpu_pkg::BR_COND, 30'h410, 30'h485, 0);
    with_redir(bpu_pkg::REDIR_RESTORE, 30'h410, 0, 30'h000);
    add_row(0, 0, 0, 30'h411, 30'h000, bpu_pkg::BR_NONE, 0, 0);
    add_row(1, 0, 1, 30'h410, 30'h411, bpu_pkg::BR_COND, 0, 0);

    // Nested calls from 0x432 via 0x4a8 into 0x4c4 with returns at 0x4c4 and 0x4a9
    with_upd(bpu_pkg::BR_CALL, 30'h432, 30'h4a8, 1);
    with_redir(bpu_pkg::REDIR_RESTORE, 30'h432, 0, 30'h000);
    add_row(0, 0, 0, 30'h411, 30'h000, bpu_pkg::BR_NONE, 0, 0);
    with_upd(bpu_pkg::BR_CALL, 30'h4a8, 30'h4c4, 1);
    add_row(1, 0, 1, 30'h432, 30'h4a8, bpu_pkg::BR_CALL, 1, 0);
    with_upd(bpu_pkg::BR_RET, 30'h4c4, 30'h000, 1);
    add_row(1, 0, 1, 30'h4a8, 30'h4c4, bpu_pkg::BR_CALL, 1, 1);
    with_upd(bpu_pkg::BR_RET, 30'h4a9, 30'h000, 1);
    add_row(1, 0, 1, 30'h4c4, 30'h4a9, bpu_pkg::BR_RET, 1, 2);
    add_row(1, 0, 1, 30'h4a9, 30'h433, bpu_pkg::BR_RET, 1, 1);
    add_row(1, 0, 1, 30'h433, 30'h434, bpu_pkg::BR_NONE, 0, 0);

    // Restore to the checkpoint of the inner call
    with_redir(bpu_pkg::REDIR_RESTORE, 30'h432, 0, 30'h000);
    add_row(0, 0, 0, 30'h434, 30'h000, bpu_pkg::BR_NONE, 0, 0);
    add_row(1, 0, 1, 30'h432, 30'h4a8, bpu_pkg::BR_CALL, 1, 0);
    add_row(1, 0, 1, 30'h4a8, 30'h4c4, bpu_pkg::BR_CALL, 1, 1);
    with_redir(bpu_pkg::REDIR_RESTORE, 30'h4a9, 1, 30'h000);
    add_row(0, 0, 0, 30'h4c4, 30'h000, bpu_pkg::BR_NONE, 0, 0);
    add_row(1, 0, 1, 30'h4a9, 30'h433, bpu_pkg::BR_RET, 1, 1);
    add_row(1, 0, 1, 30'h433, 30'h434, bpu_pkg::BR_NONE, 0, 0);

    // Repair rewrites entry 0 so the return goes to 0x4e6
    with_redir(bpu_pkg::REDIR_REPAIR, 30'h4c4, 1, 30'h4e6);
    add_row(0, 0, 0, 30'h434, 30'h000, bpu_pkg::BR_NONE, 0, 0);
    add_row(1, 0, 1, 30'h4c4, 30'h4e6, bpu_pkg::BR_RET, 1, 1);
    add_row(1, 0, 1, 30'h4e6, 30'h4e7, bpu_pkg::BR_NONE, 0, 0);
endtask

`endif

/* dv/bpu_tb.sv */
// Branch prediction unit testbench
// Table-driven cycles with the testbench acting as backend and fetch queue

`timescale 1ns/1ps

module bpu_tb;

    localparam int STACK_DEPTH = 8;
    localparam int PTR_W       = $clog2(STACK_DEPTH);
    localparam int CREDITS     = 4;

    // One cycle of stimulus and expectation
    typedef struct {
        logic                     upd_v;
        bpu_pkg::br_type_e        upd_type;
        bpu_pkg::pc_t             upd_pc;
        bpu_pkg::pc_t             upd_tgt;
        logic                     upd_tk;
        bpu_pkg::redirect_e       rk;
        bpu_pkg::pc_t             rpc;
        logic [PTR_W-1:0]         rptr;
        bpu_pkg::pc_t             rtgt;
        logic                     credit;
        logic                     gap;
        logic                     ev;
        bpu_pkg::pc_t             epc;
        bpu_pkg::pc_t             etgt;
        bpu_pkg::br_type_e        etype;
        logic                     etk;
        logic [PTR_W-1:0]         eptr;
    } vec_t;

    logic clk;
    logic rst_n;
    logic pred_valid_o;
    bpu_pkg::pc_t pred_pc_o;
    bpu_pkg::pc_t pred_target_o;
    bpu_pkg::br_type_e pred_type_o;
    logic pred_taken_o;
    logic [PTR_W-1:0] pred_ras_ptr_o;
    logic credit_i;
    logic upd_valid_i;
    bpu_pkg::pc_t upd_pc_i;
    bpu_pkg::br_type_e upd_type_i;
    logic upd_taken_i;
    bpu_pkg::pc_t upd_target_i;
    bpu_pkg::redirect_e redir_kind_i;
    bpu_pkg::pc_t redir_pc_i;
    logic [PTR_W-1:0] redir_ras_ptr_i;
    bpu_pkg::pc_t redir_ras_target_i;

    vec_t tbl[$];
    vec_t pend;
    int   errors      = 0;
    int   cycles      = 0;
    int   cycle_limit = 0;

    branch_prediction_unit #(
        .STACK_DEPTH(STACK_DEPTH),
        .CREDITS(CREDITS)
    ) i_branch_prediction_unit (
        .clk(clk), .rst_n(rst_n),
        .pred_valid_o(pred_valid_o), .pred_pc_o(pred_pc_o),
        .pred_target_o(pred_target_o), .pred_type_o(pred_type_o),
        .pred_taken_o(pred_taken_o), .pred_ras_ptr_o(pred_ras_ptr_o),
        .credit_i(credit_i),
        .upd_valid_i(upd_valid_i), .upd_pc_i(upd_pc_i), .upd_type_i(upd_type_i),
        .upd_taken_i(upd_taken_i), .upd_target_i(upd_target_i),
        .redir_kind_i(redir_kind_i), .redir_pc_i(redir_pc_i),
        .redir_ras_ptr_i(redir_ras_ptr_i), .redir_ras_target_i(redir_ras_target_i)
    );

    // ========================================================================
    // Table building
    // ========================================================================

    task automatic with_upd(input bpu_pkg::br_type_e t, input bpu_pkg::pc_t pc,
                            input bpu_pkg::pc_t tgt, input logic tk);
        pend.upd_v    = 1'b1;
        pend.upd_type = t;
        pend.upd_pc   = pc;
        pend.upd_tgt  = tgt;
        pend.upd_tk   = tk;
    endtask

    task automatic with_redir(input bpu_pkg::redirect_e k, input bpu_pkg::pc_t pc,
                              input logic [PTR_W-1:0] ptr, input bpu_pkg::pc_t tgt);
        pend.rk   = k;
        pend.rpc  = pc;
        pend.rptr = ptr;
        pend.rtgt = tgt;
    endtask

    // Commits the row and clears the pending update and redirect
    task automatic add_row(input logic cr, input logic gap, input logic ev,
                           input bpu_pkg::pc_t epc, input bpu_pkg::pc_t etgt,
                           input bpu_pkg::br_type_e et, input logic etk,
                           input logic [PTR_W-1:0] eptr);
        pend.credit = cr;
        pend.gap    = gap;
        pend.ev     = ev;
        pend.epc    = epc;
        pend.etgt   = etgt;
        pend.etype  = et;
        pend.etk    = etk;
        pend.eptr   = eptr;
        tbl.push_back(pend);
        clear_pending();
    endtask

    task automatic clear_pending();
        pend.upd_v    = 1'b0;
        pend.upd_type = bpu_pkg::BR_NONE;
        pend.upd_pc   = '0;
        pend.upd_tgt  = '0;
        pend.upd_tk   = 1'b0;
        pend.rk       = bpu_pkg::REDIR_NONE;
        pend.rpc      = '0;
        pend.rptr     = '0;
        pend.rtgt     = '0;
    endtask

    `include "bpu_vectors.svh"

    // ========================================================================
    // Compare tasks
    // ========================================================================

    task automatic check_pc(input string name, input bpu_pkg::pc_t exp,
                            input bpu_pkg::pc_t act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_type(input string name, input bpu_pkg::br_type_e exp,
                              input bpu_pkg::br_type_e act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %s actual %s", $time, name, exp.name(),
                     act.name());
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_ptr(input string name, input logic [PTR_W-1:0] exp,
                             input logic [PTR_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    // Row inputs driven just after the rising edge
    task automatic drive_row(input vec_t v);
        upd_valid_i        <= v.upd_v;
        upd_type_i         <= v.upd_type;
        upd_pc_i           <= v.upd_pc;
        upd_target_i       <= v.upd_tgt;
        upd_taken_i        <= v.upd_tk;
        redir_kind_i       <= v.rk;
        redir_pc_i         <= v.rpc;
        redir_ras_ptr_i    <= v.rptr;
        redir_ras_target_i <= v.rtgt;
        credit_i           <= v.credit;
    endtask

    // ========================================================================
    // Clock, timeout and main sequence
    // ========================================================================

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the vector table did not finish within %0d cycles",
                     cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        vec_t idle;
        int   gap_n;

        void'($urandom(32'hf398b64b));
        clear_pending();
        fill_vectors();
        cycle_limit = 2 * tbl.size() + 50;
        idle = pend;
        idle.credit = 1'b0;

        rst_n              = 1'b0;
        credit_i           = 1'b0;
        upd_valid_i        = 1'b0;
        upd_pc_i           = '0;
        upd_type_i         = bpu_pkg::BR_NONE;
        upd_taken_i        = 1'b0;
        upd_target_i       = '0;
        redir_kind_i       = bpu_pkg::REDIR_NONE;
        redir_pc_i         = '0;
        redir_ras_ptr_i    = '0;
        redir_ras_target_i = '0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        foreach (tbl[i]) begin
            // Random stall before a credit return keeps the unit idle
            if (tbl[i].gap) begin
                gap_n = $urandom_range(3, 0);
                repeat (gap_n) begin
                    drive_row(idle);
                    @(negedge clk);
                    check_bit("pred_valid_o", 1'b0, pred_valid_o);
                    check_pc("pred_pc_o", tbl[i].epc, pred_pc_o);
                    @(posedge clk);
                end
            end
            drive_row(tbl[i]);
            @(negedge clk);
            check_bit("pred_valid_o", tbl[i].ev, pred_valid_o);
            check_pc("pred_pc_o", tbl[i].epc, pred_pc_o);
            if (tbl[i].ev) begin
                check_pc("pred_target_o", tbl[i].etgt, pred_target_o);
                check_type("pred_type_o", tbl[i].etype, pred_type_o);
                check_bit("pred_taken_o", tbl[i].etk, pred_taken_o);
                check_ptr("pred_ras_ptr_o", tbl[i].eptr, pred_ras_ptr_o);
            end
            @(posedge clk);
        end

        $display("Run complete: %0d vectors, %0d errors", tbl.size(), errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* design/branch_prediction_unit.sv */
// Branch prediction unit top level
// One predicted fetch address per cycle from BTB, BHT and RAS,
// credit-metered toward the fetch queue

`timescale 1ns/1ps

`include "bpu_defaults.svh"

module branch_prediction_unit #(
    parameter int STACK_DEPTH = `RAS_STACK_DEPTH,
    parameter int BTB_ENTRIES = `BTB_ENTRIES,
    parameter int BHT_ENTRIES = `BHT_ENTRIES,
    parameter int CREDITS     = `FQ_CREDITS
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // Prediction out to the fetch queue
    output logic                              pred_valid_o,
    output bpu_pkg::pc_t                      pred_pc_o,
    output bpu_pkg::pc_t                      pred_target_o,
    output bpu_pkg::br_type_e                 pred_type_o,
    output logic                              pred_taken_o,
    output logic [$clog2(STACK_DEPTH)-1:0]    pred_ras_ptr_o,
    // Slot returned by the fetch queue
    input  logic                              credit_i,
    // Resolved branch from the backend
    input  logic                              upd_valid_i,
    input  bpu_pkg::pc_t                      upd_pc_i,
    input  bpu_pkg::br_type_e                 upd_type_i,
    input  logic                              upd_taken_i,
    input  bpu_pkg::pc_t                      upd_target_i,
    // Backend redirect with RAS checkpoint
    input  bpu_pkg::redirect_e                redir_kind_i,
    input  bpu_pkg::pc_t                      redir_pc_i,
    input  logic [$clog2(STACK_DEPTH)-1:0]    redir_ras_ptr_i,
    input  bpu_pkg::pc_t                      redir_ras_target_i
);

    localparam int PTR_W = $clog2(STACK_DEPTH);

    bpu_pkg::pc_t       fetch_pc;
    logic               btb_hit;
    bpu_pkg::br_type_e  btb_type;
    bpu_pkg::pc_t       btb_target;
    logic               bht_taken;
    logic               bht_upd_en;
    logic               ras_push;
    logic               ras_pop;
    bpu_pkg::pc_t       ras_push_target;
    bpu_pkg::pc_t       ras_top;
    logic [PTR_W-1:0]   ras_ptr;

    // Counters train on conditional branches only
    assign bht_upd_en = upd_valid_i && (upd_type_i == bpu_pkg::BR_COND);

    next_pc_gen #(.STACK_DEPTH(STACK_DEPTH), .CREDITS(CREDITS)) i_next_pc_gen (
        .clk(clk), .rst_n(rst_n),
        .btb_hit_i(btb_hit), .btb_type_i(btb_type), .btb_target_i(btb_target),
        .bht_taken_i(bht_taken), .ras_top_i(ras_top), .ras_ptr_i(ras_ptr),
        .redir_kind_i(redir_kind_i), .redir_pc_i(redir_pc_i), .credit_i(credit_i),
        .fetch_pc_o(fetch_pc), .ras_push_o(ras_push), .ras_pop_o(ras_pop),
        .ras_push_target_o(ras_push_target),
        .pred_valid_o(pred_valid_o), .pred_taken_o(pred_taken_o),
        .pred_target_o(pred_target_o), .pred_type_o(pred_type_o),
        .pred_ras_ptr_o(pred_ras_ptr_o)
    );

    branch_target_buffer #(.BTB_ENTRIES(BTB_ENTRIES)) i_branch_target_buffer (
        .clk(clk), .rst_n(rst_n),
        .rd_pc_i(fetch_pc), .hit_o(btb_hit), .type_o(btb_type), .target_o(btb_target),
        .wr_en_i(upd_valid_i), .wr_pc_i(upd_pc_i), .wr_type_i(upd_type_i),
        .wr_target_i(upd_target_i)
    );

    branch_history_table #(.BHT_ENTRIES(BHT_ENTRIES)) i_branch_history_table (
        .clk(clk), .rst_n(rst_n),
        .rd_pc_i(fetch_pc), .taken_o(bht_taken),
        .upd_en_i(bht_upd_en), .upd_pc_i(upd_pc_i), .upd_taken_i(upd_taken_i)
    );

    return_address_stack #(.STACK_DEPTH(STACK_DEPTH)) i_return_address_stack (
        .clk(clk), .rst_n(rst_n),
        .push_i(ras_push), .pop_i(ras_pop), .push_target_i(ras_push_target),
        .redir_kind_i(redir_kind_i), .redir_ptr_i(redir_ras_ptr_i),
        .redir_target_i(redir_ras_target_i),
        .top_o(ras_top), .ptr_o(ras_ptr)
    );

    // Fetch address of the current prediction
    assign pred_pc_o = fetch_pc;

endmodule

/* design/next_pc_gen.sv */
// Next-PC generator
// Holds the fetch PC, picks the next fetch address from BTB, BHT and RAS,
// drives RAS push/pop and meters predictions with fetch queue credits

`timescale 1ns/1ps

module next_pc_gen #(
    parameter int STACK_DEPTH = 8,
    parameter int CREDITS     = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // Predictor lookups
    input  logic                              btb_hit_i,
    input  bpu_pkg::br_type_e                 btb_type_i,
    input  bpu_pkg::pc_t                      btb_target_i,
    input  logic                              bht_taken_i,
    input  bpu_pkg::pc_t                      ras_top_i,
    input  logic [$clog2(STACK_DEPTH)-1:0]    ras_ptr_i,
    // Backend redirect and fetch queue credits
    input  bpu_pkg::redirect_e                redir_kind_i,
    input  bpu_pkg::pc_t                      redir_pc_i,
    input  logic                              credit_i,
    // Lookup address and stack control
    output bpu_pkg::pc_t                      fetch_pc_o,
    output logic                              ras_push_o,
    output logic                              ras_pop_o,
    output bpu_pkg::pc_t                      ras_push_target_o,
    // Prediction to the fetch queue
    output logic                              pred_valid_o,
    output logic                              pred_taken_o,
    output bpu_pkg::pc_t                      pred_target_o,
    output bpu_pkg::br_type_e                 pred_type_o,
    output logic [$clog2(STACK_DEPTH)-1:0]    pred_ras_ptr_o
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    bpu_pkg::pc_t       fetch_pc_q;
    logic [CNT_W-1:0]   credit_q;
    logic               issue;
    bpu_pkg::pc_t       seq_pc;
    bpu_pkg::br_type_e  pred_type;
    logic               pred_taken;
    bpu_pkg::pc_t       next_pc;

    // ========================================================================
    // Prediction
    // ========================================================================

    // Needs a free slot and no redirect this cycle
    assign issue  = (credit_q != '0) && (redir_kind_i == bpu_pkg::REDIR_NONE);
    assign seq_pc = fetch_pc_q + 30'd1;

    // Miss looks like a plain instruction
    assign pred_type = btb_hit_i ? btb_type_i : bpu_pkg::BR_NONE;

    always_comb begin
        pred_taken = 1'b0;
        next_pc    = seq_pc;
        case (pred_type)
            bpu_pkg::BR_JUMP, bpu_pkg::BR_CALL: begin
                pred_taken = 1'b1;
                next_pc    = btb_target_i;
            end
            bpu_pkg::BR_COND: begin
                // Counter MSB decides direction
                pred_taken = bht_taken_i;
                next_pc    = bht_taken_i ? btb_target_i : seq_pc;
            end
            bpu_pkg::BR_RET: begin
                pred_taken = 1'b1;
                next_pc    = ras_top_i;
            end
            default: begin
                pred_taken = 1'b0;
                next_pc    = seq_pc;
            end
        endcase
    end

    // Stack moves only with an issued prediction
    assign ras_push_o        = issue && (pred_type == bpu_pkg::BR_CALL);
    assign ras_pop_o         = issue && (pred_type == bpu_pkg::BR_RET);
    assign ras_push_target_o = seq_pc;

    // ========================================================================
    // Fetch PC and credits
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_pc_q <= bpu_pkg::RESET_PC;
        end else if (redir_kind_i != bpu_pkg::REDIR_NONE) begin
            fetch_pc_q <= redir_pc_i;
        end else if (issue) begin
            fetch_pc_q <= next_pc;
        end
    end

    // Take one per prediction, return one per pulse, both may coincide
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_q <= CNT_W'(CREDITS);
        end else if (issue && !credit_i) begin
            credit_q <= credit_q - CNT_W'(1);
        end else if (!issue && credit_i) begin
            credit_q <= credit_q + CNT_W'(1);
        end
    end

    assign fetch_pc_o     = fetch_pc_q;
    assign pred_valid_o   = issue;
    assign pred_taken_o   = pred_taken;
    assign pred_target_o  = next_pc;
    assign pred_type_o    = pred_type;
    // Checkpoint taken before this prediction's push or pop
    assign pred_ras_ptr_o = ras_ptr_i;

endmodule

/* design/branch_history_table.sv */
// Branch history table
// 2-bit saturating counters predicting conditional branch direction
// Indexed by fetch PC, trained by resolved conditional branches

`timescale 1ns/1ps

module branch_history_table #(
    parameter int BHT_ENTRIES = 64
) (
    input  logic          clk,
    input  logic          rst_n,
    input  bpu_pkg::pc_t  rd_pc_i,
    output logic          taken_o,
    input  logic          upd_en_i,
    input  bpu_pkg::pc_t  upd_pc_i,
    input  logic          upd_taken_i
);

    localparam int IDX_W = $clog2(BHT_ENTRIES);

    // 00 strong NT, 01 weak NT, 10 weak T, 11 strong T
    logic [1:0]       cnt_q [BHT_ENTRIES];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] upd_idx;

    assign rd_idx  = rd_pc_i[IDX_W+1:2];
    assign upd_idx = upd_pc_i[IDX_W+1:2];

    // One step toward the outcome, held at both ends
    function automatic logic [1:0] sat_step(input logic [1:0] cnt, input logic taken);
        logic [1:0] res;
        res = cnt;
        if (taken && cnt != 2'b11) begin
            res = cnt + 2'b01;
        end else if (!taken && cnt != 2'b00) begin
            res = cnt - 2'b01;
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Everything starts weakly not-taken
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                cnt_q[i] <= 2'b01;
            end
        end else if (upd_en_i) begin
            cnt_q[upd_idx] <= sat_step(cnt_q[upd_idx], upd_taken_i);
        end
    end

    // Direction is the counter MSB
    assign taken_o = cnt_q[rd_idx][1];

endmodule

/* design/branch_target_buffer.sv */
// Branch target buffer
// Direct-mapped, untagged table of branch type and target per fetch address
// Combinational read by fetch PC, written by backend updates

`timescale 1ns/1ps

module branch_target_buffer #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    // Fetch side lookup
    input  bpu_pkg::pc_t       rd_pc_i,
    output logic               hit_o,
    output bpu_pkg::br_type_e  type_o,
    output bpu_pkg::pc_t       target_o,
    // Backend update
    input  logic               wr_en_i,
    input  bpu_pkg::pc_t       wr_pc_i,
    input  bpu_pkg::br_type_e  wr_type_i,
    input  bpu_pkg::pc_t       wr_target_i
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);

    // ========================================================================
    // Storage
    // ========================================================================

    // One valid bit per entry
    logic [BTB_ENTRIES-1:0] valid_q;
    // Payload arrays
    bpu_pkg::br_type_e      type_q   [BTB_ENTRIES];
    bpu_pkg::pc_t           target_q [BTB_ENTRIES];

    // Low word-address bits select the entry
    // No tag, so aliasing addresses share one slot
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx = rd_pc_i[IDX_W+1:2];
    assign wr_idx = wr_pc_i[IDX_W+1:2];

    // ========================================================================
    // Update
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            // Type NONE retires the entry
            valid_q[wr_idx] <= (wr_type_i != bpu_pkg::BR_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            type_q[wr_idx]   <= wr_type_i;
            target_q[wr_idx] <= wr_target_i;
        end
    end

    // ========================================================================
    // Lookup
    // ========================================================================

    // Old contents seen on a same-cycle update
    assign hit_o    = valid_q[rd_idx];
    // Raw fields qualified by hit_o downstream
    assign type_o   = type_q[rd_idx];
    assign target_o = target_q[rd_idx];

endmodule

/* design/return_address_stack.sv */
// Return address stack
// Circular stack of return addresses with push, pop and a pointer checkpoint
// Backend redirects restore the pointer and can rewrite the entry below it

`timescale 1ns/1ps

module return_address_stack #(
    parameter int STACK_DEPTH = 8
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              push_i,
    input  logic                              pop_i,
    input  bpu_pkg::pc_t                      push_target_i,
    input  bpu_pkg::redirect_e                redir_kind_i,
    input  logic [$clog2(STACK_DEPTH)-1:0]    redir_ptr_i,
    input  bpu_pkg::pc_t                      redir_target_i,
    output bpu_pkg::pc_t                      top_o,
    output logic [$clog2(STACK_DEPTH)-1:0]    ptr_o
);

    localparam int PTR_W = $clog2(STACK_DEPTH);

    // Return address storage
    bpu_pkg::pc_t     stack_q [STACK_DEPTH];
    // Points at the next free slot
    logic [PTR_W-1:0] ptr_q;
    // Entry below the pointer holds the most recent push
    logic [PTR_W-1:0] top_idx;
    logic [PTR_W-1:0] repair_idx;

    assign top_idx    = ptr_q - PTR_W'(1);
    assign repair_idx = redir_ptr_i - PTR_W'(1);

    // Redirect wins over push and pop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (redir_kind_i != bpu_pkg::REDIR_NONE) begin
            ptr_q <= redir_ptr_i;
        end else if (push_i) begin
            // Wraps on overflow
            ptr_q <= ptr_q + PTR_W'(1);
        end else if (pop_i) begin
            ptr_q <= top_idx;
        end
    end

    // Entry writes
    always_ff @(posedge clk) begin
        if (redir_kind_i == bpu_pkg::REDIR_REPAIR) begin
            stack_q[repair_idx] <= redir_target_i;
        end else if (redir_kind_i == bpu_pkg::REDIR_NONE && push_i) begin
            // Oldest entry silently lost on overflow
            stack_q[ptr_q] <= push_target_i;
        end
    end

    assign top_o = stack_q[top_idx];
    assign ptr_o = ptr_q;

endmodule

/* design/bpu_pkg.sv */
// Branch prediction unit package
// Word address type, branch and redirect encodings, reset fetch address

package bpu_pkg;

    // ========================================================================
    // Address
    // ========================================================================

    // Word address, byte offset bits dropped
    typedef logic [31:2] pc_t;

    // First fetch address after reset (byte address 0x1000)
    localparam pc_t RESET_PC = 30'h0000_0400;

    // ========================================================================
    // Encodings
    // ========================================================================

    // Branch kind as recorded in the target buffer
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_COND = 3'd1,
        BR_JUMP = 3'd2,
        BR_CALL = 3'd3,
        BR_RET  = 3'd4
    } br_type_e;

    // Backend redirect kind
    // Restore moves the stack pointer back to a checkpoint
    // Repair also rewrites the entry just below that checkpoint
    typedef enum logic [1:0] {
        REDIR_NONE    = 2'd0,
        REDIR_RESTORE = 2'd1,
        REDIR_REPAIR  = 2'd2
    } redirect_e;

endpackage

/* include/bpu_defaults.svh */
// Branch prediction unit default sizes
// Top-level parameter defaults, overridable per instance

`ifndef BPU_DEFAULTS_SVH
`define BPU_DEFAULTS_SVH

// Return address stack entries, power of two
`define RAS_STACK_DEPTH 8
// Direct-mapped target buffer entries, power of two
`define BTB_ENTRIES 16
// Saturating counter table entries, power of two
`define BHT_ENTRIES 64
// Fetch queue slots granted as credits
`define FQ_CREDITS 4

`endif
